// ==== source/zbt_pkg.sv ====
// shared types for the pipelined no-turnaround burst sram
package zbt_pkg;

  // one byte lane, nine bits incl. parity bit
  parameter int BYTE_W = 9;

  // lanes per data word
  parameter int NUM_BYTES = 2;

  // data word as seen by the core
  // whole = flat 18-bit word, lanes = two byte lanes for byte writes
  typedef union packed {
    logic [NUM_BYTES*BYTE_W-1:0]           whole;  // flat word
    logic [NUM_BYTES-1:0][BYTE_W-1:0]      lanes;  // lanes[1] is the upper byte
  } word_u;

  // operation of a burst and of one pipeline stage
  typedef enum logic [1:0] {
    OP_IDLE  = 2'd0,  // deselected, nothing happens
    OP_READ  = 2'd1,  // read access
    OP_WRITE = 2'd2   // late write, data two enabled cycles later
  } op_e;

  // one access as it travels down the pipe
  typedef struct packed {
    op_e                  op;    // what this stage does
    logic [NUM_BYTES-1:0] be_n;  // byte selects, active low, writes only
  } access_t;

endpackage

// ==== source/zbt_cmd_fsm.sv ====
// command decode and burst state
// state is the op of the current burst, set on loads and kept on advances
// output registers form stage 1 of the pipe
module zbt_cmd_fsm (
  input  logic                             clk,
  input  logic                             rst_n_i,
  input  logic                             cen_n_i,   // clock enable, low active
  input  logic                             ce1_n_i,
  input  logic                             ce2_i,
  input  logic                             ce3_n_i,
  input  logic                             adv_ld_i,  // 1 advance, 0 load
  input  logic                             we_n_i,
  input  logic [zbt_pkg::NUM_BYTES-1:0]    bw_n_i,
  output logic                             load_o,    // stage 1 is a load
  output logic                             adv_o,     // stage 1 is an advance
  output zbt_pkg::access_t                 acc_o      // stage 1 access
);

  logic             sel_w;       // all three chip enables active
  logic             load_w;      // load command on the pins
  zbt_pkg::op_e     burst_op_q;  // fsm state, op of the running burst
  zbt_pkg::op_e     burst_op_d;
  zbt_pkg::access_t acc_q;
  logic             load_q;
  logic             adv_q;

  assign sel_w  = ~ce1_n_i & ce2_i & ~ce3_n_i;
  assign load_w = ~adv_ld_i;

  // next state
  // a load picks the op from chip select and we_n, an advance repeats it
  always_comb
  begin
    burst_op_d = burst_op_q;  // advance keeps the burst going
    if (load_w)
    begin
      case ({sel_w, we_n_i})
        2'b10:   burst_op_d = zbt_pkg::OP_WRITE;  // selected, we low
        2'b11:   burst_op_d = zbt_pkg::OP_READ;   // selected, we high
        default: burst_op_d = zbt_pkg::OP_IDLE;   // deselect
      endcase
    end
  end

  // state register, holds while cen_n_i is high
  always_ff @(posedge clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      burst_op_q <= zbt_pkg::OP_IDLE;
    end
    else if (!cen_n_i)
    begin
      burst_op_q <= burst_op_d;  // we and ce pins ignored on advances
    end
  end

  // stage 1 registers
  // bw_n sampled with every command, the array ignores it on reads
  always_ff @(posedge clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      acc_q.op   <= zbt_pkg::OP_IDLE;
      acc_q.be_n <= '1;  // no lanes
      load_q     <= 1'b0;
      adv_q      <= 1'b0;
    end
    else if (!cen_n_i)
    begin
      acc_q.op   <= burst_op_d;  // decoded op of this command
      acc_q.be_n <= bw_n_i;
      load_q     <= load_w;
      adv_q      <= adv_ld_i;    // idle bursts still step the counter
    end
  end

  assign acc_o  = acc_q;
  assign load_o = load_q;
  assign adv_o  = adv_q;

endmodule

// ==== source/zbt_burst_counter.sv ====
// burst address counter
// only the low two bits move, upper bits fixed for the whole burst
module zbt_burst_counter #(
  parameter int ADDR_W = 8
) (
  input  logic              clk,
  input  logic              rst_n_i,
  input  logic              cen_n_i,
  input  logic              mode_i,   // 1 interleaved, 0 linear
  input  logic [ADDR_W-1:0] a_i,
  input  logic              load_i,   // stage 1 load, from the fsm
  input  logic              adv_i,    // stage 1 advance, from the fsm
  output logic [ADDR_W-1:0] addr_o    // address of the stage 1 access
);

  logic [ADDR_W-1:0] a_q;     // address pins, lined up with stage 1
  logic              mode_q;  // burst order pin, sampled with the command
  logic [ADDR_W-1:0] addr_q;  // last access address
  logic              init_q;  // bit 0 of the start address
  logic [1:0]        step_w;  // next low bits

  // command edge capture
  always_ff @(posedge clk)
  begin
    if (!cen_n_i)
    begin
      a_q    <= a_i;
      mode_q <= mode_i;
    end
  end

  // linear 0-1-2-3 order is +1 with wrap
  // interleaved order 0->3 1->0 2->1 3->2 is -1 with wrap
  // odd start in interleaved mode only, even start always counts up
  always_comb
  begin
    if (!mode_q || !init_q)
      step_w = addr_q[1:0] + 2'd1;
    else
      step_w = addr_q[1:0] - 2'd1;
  end

  assign addr_o = load_i ? a_q :
                  adv_i  ? {addr_q[ADDR_W-1:2], step_w} :
                           addr_q;  // nothing issued yet after reset

  always_ff @(posedge clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      addr_q <= '0;
      init_q <= 1'b0;
    end
    else if (!cen_n_i)
    begin
      addr_q <= addr_o;  // next advance steps from here
      if (load_i)
        init_q <= a_q[0];  // burst type follows start bit 0
    end
  end

endmodule

// ==== source/zbt_mem_array.sv ====
// storage, late-write stage, forwarding and read pipe
// edge N+1: read into rd_q, or write addr/selects into the late-write stage
// edge N+2: rd_q to q_o, write data sampled and committed
module zbt_mem_array #(
  parameter int ADDR_W = 8
) (
  input  logic              clk,
  input  logic              rst_n_i,
  input  logic              cen_n_i,
  input  zbt_pkg::access_t  acc_i,      // stage 1 access
  input  logic [ADDR_W-1:0] addr_i,     // stage 1 address
  input  zbt_pkg::word_u    d_i,        // write data, two enabled cycles late
  output zbt_pkg::word_u    q_o,
  output logic              q_valid_o   // q_o holds read data
);

  localparam int DEPTH = 2**ADDR_W;

  zbt_pkg::word_u                     mem_q [DEPTH];  // the array itself
  logic                               wr_valid_q;     // late write pending
  logic [ADDR_W-1:0]                  wr_addr_q;
  logic [zbt_pkg::NUM_BYTES-1:0]      wr_be_n_q;
  zbt_pkg::word_u                     merged_w;       // word after the commit
  logic                               fwd_w;          // read hits the commit
  logic                               rd_w;           // stage 1 is a read
  zbt_pkg::word_u                     rd_q;           // read register
  logic                               rd_valid_q;

  assign rd_w = (acc_i.op == zbt_pkg::OP_READ);

  // old word with the selected lanes of d_i laid over it
  always_comb
  begin
    merged_w = mem_q[wr_addr_q];
    for (int i = 0; i < zbt_pkg::NUM_BYTES; i++)
    begin
      if (!wr_be_n_q[i])
        merged_w.lanes[i] = d_i.lanes[i];  // this lane written
    end
  end

  // a read issued right after a write to the same address
  // must see the committing data, array still holds the old word
  assign fwd_w = wr_valid_q && rd_w && (wr_addr_q == addr_i);

  // commit
  always_ff @(posedge clk)
  begin
    if (!cen_n_i && wr_valid_q)
      mem_q[wr_addr_q] <= merged_w;
  end

  // late-write stage, one write in flight at a time
  always_ff @(posedge clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
      wr_valid_q <= 1'b0;
    else if (!cen_n_i)
      wr_valid_q <= (acc_i.op == zbt_pkg::OP_WRITE);
  end

  always_ff @(posedge clk)
  begin
    if (!cen_n_i)
    begin
      wr_addr_q <= addr_i;
      wr_be_n_q <= acc_i.be_n;  // bytes masked at commit time
    end
  end

  // read register and output register
  // idle and write stages push zero so q_o is clean when not valid
  always_ff @(posedge clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      rd_q       <= '0;
      rd_valid_q <= 1'b0;
      q_o        <= '0;
      q_valid_o  <= 1'b0;
    end
    else if (!cen_n_i)
    begin
      if (fwd_w)
        rd_q <= merged_w;        // forwarded
      else if (rd_w)
        rd_q <= mem_q[addr_i];
      else
        rd_q <= '0;
      rd_valid_q <= rd_w;
      q_o        <= rd_q;        // second enabled edge after the command
      q_valid_o  <= rd_valid_q;
    end
  end

endmodule

// ==== source/zbt_sram.sv ====
// pipelined burst sram, no turnaround cycles between reads and writes
// read data two enabled cycles after the command, write data due at the same point
module zbt_sram #(
  parameter int ADDR_W = 8
) (
  input  logic                          clk,
  input  logic                          rst_n_i,
  input  logic                          cen_n_i,   // global clock enable, low active
  input  logic                          ce1_n_i,
  input  logic                          ce2_i,
  input  logic                          ce3_n_i,
  input  logic                          adv_ld_i,
  input  logic                          we_n_i,
  input  logic [zbt_pkg::NUM_BYTES-1:0] bw_n_i,
  input  logic                          mode_i,
  input  logic [ADDR_W-1:0]             a_i,
  input  zbt_pkg::word_u                d_i,
  output zbt_pkg::word_u                q_o,
  output logic                          q_valid_o
);

  logic              load_w;  // stage 1 load
  logic              adv_w;   // stage 1 advance
  zbt_pkg::access_t  acc_w;   // stage 1 access
  logic [ADDR_W-1:0] addr_w;  // stage 1 address

  // command decode, burst op state
  zbt_cmd_fsm cmd_fsm_i (
    .clk      (clk),
    .rst_n_i  (rst_n_i),
    .cen_n_i  (cen_n_i),
    .ce1_n_i  (ce1_n_i),
    .ce2_i    (ce2_i),
    .ce3_n_i  (ce3_n_i),
    .adv_ld_i (adv_ld_i),
    .we_n_i   (we_n_i),
    .bw_n_i   (bw_n_i),
    .load_o   (load_w),
    .adv_o    (adv_w),
    .acc_o    (acc_w)
  );

  // address sequencing
  zbt_burst_counter #(
    .ADDR_W (ADDR_W)
  ) burst_counter_i (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .cen_n_i (cen_n_i),
    .mode_i  (mode_i),
    .a_i     (a_i),
    .load_i  (load_w),
    .adv_i   (adv_w),
    .addr_o  (addr_w)
  );

  // storage and data pipe
  zbt_mem_array #(
    .ADDR_W (ADDR_W)
  ) mem_array_i (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .cen_n_i   (cen_n_i),
    .acc_i     (acc_w),
    .addr_i    (addr_w),
    .d_i       (d_i),
    .q_o       (q_o),
    .q_valid_o (q_valid_o)
  );

endmodule

// ==== bench/zbt_sram_tb.sv ====
module zbt_sram_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int ADDR_W = 8;
  localparam int N_RAND = 200;  // test 4 length
  localparam int N_REP  = 100;  // test 6 length, per run
  // enabled commands of all tests, drains included
  localparam int N_CMDS = 260 + 6 + 12 + 100 + (N_RAND + 4) + 28 + 2 * (16 + N_REP + 4);

  // one command as put on the pins
  typedef struct packed {
    logic              adv;    // 1 advance, 0 load
    logic              ce1_n;
    logic              ce2;
    logic              ce3_n;
    logic              we_n;
    logic [1:0]        bw_n;
    logic              mode;
    logic [ADDR_W-1:0] a;
    zbt_pkg::word_u    d;      // late-write data, goes out two commands later
  } cmd_t;

  typedef struct packed {
    logic [31:0]    due;  // enabled edge count with q_valid_o high
    zbt_pkg::word_u w;
  } exp_t;

  logic              clk;
  logic              rst_n_i;
  logic              cen_n_i;
  logic              ce1_n_i;
  logic              ce2_i;
  logic              ce3_n_i;
  logic              adv_ld_i;
  logic              we_n_i;
  logic [1:0]        bw_n_i;
  logic              mode_i;
  logic [ADDR_W-1:0] a_i;
  zbt_pkg::word_u    d_i;
  zbt_pkg::word_u    q_o;
  logic              q_valid_o;

  logic [31:0]    rnd = 32'd60;                   // command stream
  logic [31:0]    g_rnd = 32'd60 ^ 32'h9e3779b9;  // gap stream, kept apart
  zbt_pkg::word_u mem_m [2**ADDR_W];              // shadow memory
  zbt_pkg::op_e   m_op = zbt_pkg::OP_IDLE;        // shadow burst op
  logic [ADDR_W-1:0] m_addr = '0;
  logic           m_odd = 1'b0;                   // start bit 0 of the burst
  zbt_pkg::word_u dq [2] = '{default: '0};        // data of the last two commands
  exp_t           exp_q [$];
  int             exp_rd = 0;                     // next entry due
  int             issued = 0;
  int             en_cnt = 0;
  logic           cen_last = 1'b1;                // enable seen by the coming edge
  zbt_pkg::word_u exp_w;
  logic           exp_v;
  zbt_pkg::word_u held_w = '0;                    // outputs after the last enabled edge
  logic           held_v = 1'b0;
  int             rec_sel = 0;                    // test 6 run being recorded
  zbt_pkg::word_u run_a [$];
  zbt_pkg::word_u run_b [$];
  int             errors = 0;
  int             end_errors = 0;
  int             checks = 0;
  int             n_tests = 0;
  int             err_mark = 0;

  zbt_sram #(
    .ADDR_W (ADDR_W)
  ) zbt_sram_i (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .cen_n_i   (cen_n_i),
    .ce1_n_i   (ce1_n_i),
    .ce2_i     (ce2_i),
    .ce3_n_i   (ce3_n_i),
    .adv_ld_i  (adv_ld_i),
    .we_n_i    (we_n_i),
    .bw_n_i    (bw_n_i),
    .mode_i    (mode_i),
    .a_i       (a_i),
    .d_i       (d_i),
    .q_o       (q_o),
    .q_valid_o (q_valid_o)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // address-dependent fill, every address bit shows up
  function automatic logic [17:0] fill_word(input logic [ADDR_W-1:0] a);
    return {a ^ 8'h5a, 2'b10, ~a};
  endfunction

  function automatic cmd_t make_cmd(input logic adv, input logic we_n,
                                    input logic [ADDR_W-1:0] a, input logic [17:0] d,
                                    input logic [1:0] bw_n, input logic mode);
    cmd_t c;
    c.adv    = adv;
    c.ce1_n  = 1'b0;  // selected
    c.ce2    = 1'b1;
    c.ce3_n  = 1'b0;
    c.we_n   = we_n;
    c.bw_n   = bw_n;
    c.mode   = mode;
    c.a      = a;
    c.d.whole = d;
    return c;
  endfunction

  function automatic cmd_t random_cmd(input logic [31:0] r);
    cmd_t c;
    // small address window so reads often hit recent writes
    c = make_cmd(r[0], r[2], {4'b0000, r[12:9]}, r[30:13], r[7:6], r[8]);
    c.ce2 = (r[5:3] != 3'd0);  // rare deselect
    return c;
  endfunction

  // reference model, one command in command order
  function automatic void predict(input cmd_t c, input int edge_no);
    exp_t       e;
    logic [1:0] lo;
    if (!c.adv)
    begin
      if (!c.ce1_n && c.ce2 && !c.ce3_n)
      begin
        if (c.we_n)
          m_op = zbt_pkg::OP_READ;
        else
          m_op = zbt_pkg::OP_WRITE;
      end
      else
        m_op = zbt_pkg::OP_IDLE;
      m_addr = c.a;
      m_odd  = c.a[0];
    end
    else
    begin
      lo = m_addr[1:0] + 2'd1;  // linear
      if (c.mode && m_odd)
      begin
        case (m_addr[1:0])      // interleaved table
          2'd0: lo = 2'd3;
          2'd1: lo = 2'd0;
          2'd2: lo = 2'd1;
          default: lo = 2'd2;
        endcase
      end
      m_addr[1:0] = lo;         // upper bits untouched
    end
    if (m_op == zbt_pkg::OP_WRITE)
    begin
      for (int i = 0; i < zbt_pkg::NUM_BYTES; i++)
        if (!c.bw_n[i])
          mem_m[m_addr].lanes[i] = c.d.lanes[i];
    end
    else if (m_op == zbt_pkg::OP_READ)
    begin
      e.due = edge_no + 2;
      e.w   = mem_m[m_addr];
      exp_q.push_back(e);
    end
  endfunction

  task automatic drive(input cmd_t c);
    @(posedge clk);
    cen_n_i  <= 1'b0;
    adv_ld_i <= c.adv;
    ce1_n_i  <= c.ce1_n;
    ce2_i    <= c.ce2;
    ce3_n_i  <= c.ce3_n;
    we_n_i   <= c.we_n;
    bw_n_i   <= c.bw_n;
    mode_i   <= c.mode;
    a_i      <= c.a;
    d_i      <= dq[1];  // data of the command two back
    dq[1] = dq[0];
    dq[0] = c.d;
    issued++;
    predict(c, issued);
  endtask

  // clock enable off, junk on the other pins
  task automatic freeze(input int n);
    repeat (n)
    begin
      @(posedge clk);
      g_rnd = xorshift(g_rnd);
      cen_n_i   <= 1'b1;
      adv_ld_i  <= g_rnd[0];
      we_n_i    <= g_rnd[1];
      ce1_n_i   <= g_rnd[2];
      a_i       <= g_rnd[10:3];
      d_i.whole <= g_rnd[28:11];
    end
  endtask

  task automatic idle(input int n);
    cmd_t c;
    c = make_cmd(1'b0, 1'b1, '0, '0, 2'b11, 1'b0);
    c.ce1_n = 1'b1;  // deselected load
    repeat (n) drive(c);
  endtask

  // window refill, then the same random stream
  task automatic replay(input logic [31:0] seed, input logic with_gaps);
    logic [31:0] r;
    r = seed;
    for (int i = 0; i < 16; i++)
      drive(make_cmd(1'b0, 1'b0, 8'(i), fill_word(8'(i)), 2'b00, 1'b0));
    for (int i = 0; i < N_REP; i++)
    begin
      r = xorshift(r);
      if (with_gaps)
      begin
        g_rnd = xorshift(g_rnd);
        if (g_rnd[1:0] == 2'd0)
          freeze(int'(g_rnd[3:2]) + 1);
      end
      drive(random_cmd(r));
    end
    idle(4);
  endtask

  task automatic flag_mismatch(input string sig, input logic [17:0] exp,
                               input logic [17:0] got);
    errors++;
    $display("mismatch at time %0t: %s expected %h got %h", $time, sig, exp, got);
  endtask

  task automatic end_test(input string name);
    int tot;
    tot = errors + end_errors;
    $display("test %0d %s: %0d errors", n_tests + 1, name, tot - err_mark);
    n_tests++;
    err_mark = tot;
  endtask

  // compare at negedge, outputs settled
  always @(negedge clk)
  begin
    if (rst_n_i && !cen_last)
    begin
      en_cnt++;
      exp_w = '0;  // zero when no read is due
      exp_v = 1'b0;
      if (exp_rd < exp_q.size() && exp_q[exp_rd].due == en_cnt)
      begin
        exp_w = exp_q[exp_rd].w;
        exp_v = 1'b1;
        exp_rd++;
      end
      checks++;
      assert (q_valid_o === exp_v)
        else flag_mismatch("q_valid_o", 18'(exp_v), 18'(q_valid_o));
      assert (q_o === exp_w)
        else flag_mismatch("q_o", exp_w.whole, q_o.whole);
      if (exp_v && rec_sel == 1)
        run_a.push_back(q_o);
      if (exp_v && rec_sel == 2)
        run_b.push_back(q_o);
      held_w = q_o;
      held_v = q_valid_o;
    end
    else if (rst_n_i)
    begin
      checks++;  // frozen edge, nothing may move
      assert (q_valid_o === held_v)
        else flag_mismatch("q_valid_o", 18'(held_v), 18'(q_valid_o));
      assert (q_o === held_w)
        else flag_mismatch("q_o", held_w.whole, q_o.whole);
    end
    cen_last = cen_n_i;
  end

  initial
  begin
    #(N_CMDS * 20 * 4);
    $display("run timed out after %0d ns, the DUT or the stimulus is stuck", N_CMDS * 80);
    $display("TEST FAIL");
    $finish;
  end

  initial
  begin
    cmd_t              c;
    logic [ADDR_W-1:0] a;
    logic [31:0]       seed;
    rst_n_i  <= 1'b0;
    cen_n_i  <= 1'b1;
    ce1_n_i  <= 1'b1;
    ce2_i    <= 1'b0;
    ce3_n_i  <= 1'b1;
    adv_ld_i <= 1'b0;
    we_n_i   <= 1'b1;
    bw_n_i   <= 2'b11;
    mode_i   <= 1'b0;
    a_i      <= '0;
    d_i      <= '0;
    repeat (16) @(posedge clk);
    rst_n_i <= 1'b1;

    for (int i = 0; i < 2**ADDR_W; i++)  // known contents everywhere
      drive(make_cmd(1'b0, 1'b0, 8'(i), fill_word(8'(i)), 2'b00, 1'b0));
    idle(4);

    rnd = xorshift(rnd);  // write, read right behind it
    drive(make_cmd(1'b0, 1'b0, rnd[7:0], rnd[25:8], 2'b00, 1'b0));
    drive(make_cmd(1'b0, 1'b1, rnd[7:0], '0, 2'b11, 1'b0));
    idle(4);
    end_test("single write and read");

    rnd = xorshift(rnd);
    a = rnd[7:0];
    for (int i = 0; i < 4; i++)
    begin
      rnd = xorshift(rnd);
      drive(make_cmd(1'b0, 1'b0, a, rnd[17:0], 2'(i), 1'b0));
      drive(make_cmd(1'b0, 1'b1, a, '0, 2'b11, 1'b0));
    end
    idle(4);
    end_test("byte writes");

    for (int m = 0; m < 2; m++)
    begin
      for (int o = 0; o < 4; o++)
      begin
        rnd = xorshift(rnd);
        a = {rnd[7:2], 2'(o)};
        for (int b = 0; b < 4; b++)
        begin
          rnd = xorshift(rnd);
          drive(make_cmd(b != 0, 1'b0, a, rnd[17:0], 2'b00, m[0]));
        end
        for (int b = 0; b < 4; b++)
          drive(make_cmd(b != 0, 1'b1, a, '0, 2'b11, m[0]));
        // single loads of the block, burst order shows in the placement
        for (int b = 0; b < 4; b++)
          drive(make_cmd(1'b0, 1'b1, {a[7:2], 2'(b)}, '0, 2'b11, 1'b0));
      end
    end
    idle(4);
    end_test("bursts, linear and interleaved");

    for (int i = 0; i < N_RAND; i++)
    begin
      rnd = xorshift(rnd);
      drive(random_cmd(rnd));
    end
    idle(4);
    end_test("random back to back");

    for (int k = 0; k < 3; k++)
    begin
      rnd = xorshift(rnd);
      a = rnd[7:0];
      c = make_cmd(1'b0, 1'b0, a, rnd[25:8], 2'b00, 1'b0);
      c.ce1_n = (k == 0);  // one pin off at a time
      c.ce2   = (k != 1);
      c.ce3_n = (k == 2);
      drive(c);
      for (int b = 0; b < 3; b++)
      begin
        rnd = xorshift(rnd);
        drive(make_cmd(1'b1, 1'b0, a, rnd[17:0], 2'b00, 1'b0));  // pins selected, ignored
      end
      for (int b = 0; b < 4; b++)
        drive(make_cmd(b != 0, 1'b1, a, '0, 2'b11, 1'b0));
    end
    idle(4);
    end_test("deselect");

    seed = rnd;
    rec_sel = 1;
    replay(seed, 1'b0);
    rec_sel = 2;
    replay(seed, 1'b1);
    rec_sel = 0;
    assert (run_a.size() == run_b.size())
      else
      begin
        end_errors++;
        $display("gapped run gave %0d reads instead of %0d", run_b.size(), run_a.size());
      end
    for (int i = 0; i < run_a.size() && i < run_b.size(); i++)
      assert (run_a[i] === run_b[i])
        else
        begin
          end_errors++;
          $display("mismatch at time %0t: q_o read %0d expected %h got %h",
                   $time, i, run_a[i].whole, run_b[i].whole);
        end
    end_test("clock enable gaps");

    assert (exp_rd == exp_q.size())
      else
      begin
        end_errors++;
        $display("%0d expected reads never showed up", exp_q.size() - exp_rd);
      end
    $display("%0d tests, %0d checks, %0d errors", n_tests, checks, errors + end_errors);
    if (errors + end_errors == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule

// ==== all.f ====
source/zbt_pkg.sv
source/zbt_cmd_fsm.sv
source/zbt_burst_counter.sv
source/zbt_mem_array.sv
source/zbt_sram.sv
bench/zbt_sram_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := zbt_sram_tb
FLIST      := all.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert -j 0 --Mdir $(OBJ_DIR)
PASS_MSG   := TEST PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

# pass only if the run printed the pass line
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
